// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 40 ns dsp_clk, reset high for 8 rising edges
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic dsp_clk_o,
   output logic wb_rst_o
);

   // Free-running clock, 20 ns half period
   initial begin
      dsp_clk_o = 1'b0;
      forever #20 dsp_clk_o = ~dsp_clk_o;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      wb_rst_o = 1'b1;
      repeat (8) @(posedge dsp_clk_o);
      @(negedge dsp_clk_o);
      wb_rst_o = 1'b0;
   end

endmodule

`default_nettype wire

// ==== bench/tb_u2_checker.sv ====
/*
 * Testbench checker
 * Models the control registers and cycle count, checks acks and read data
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module tb_u2_checker (
   input  wire                      dsp_clk_i,
   input  wire                      wb_rst_i,
   input  u2_ctrl_pkg::wb_req_t     req_i,
   input  u2_ctrl_pkg::wb_rsp_t     rsp_i,
   input  u2_ctrl_pkg::irq_src_t    irq_src_i,
   input  u2_ctrl_pkg::board_ctrl_t board_i,
   input  wire [1:0]                exp_kind_i,
   input  wire [`U2_DW-1:0]         exp_data_i,
   output int                       checks_o,
   output int                       value_errs_o,
   output int                       proto_errs_o
);

   // Read expectation kinds
   localparam logic [1:0] EXP_NONE   = 2'd0;
   localparam logic [1:0] EXP_DATA   = 2'd1;
   localparam logic [1:0] EXP_CYCLES = 2'd2;

   int                n_checks = 0;
   int                n_value_errs = 0;
   int                n_proto_errs = 0;
   // Register model
   logic [4:0]        clk_m;
   logic [3:0]        ser_m;
   logic [3:0]        adc_m;
   logic              phy_rst_m;
   logic [7:0]        led_sw_m;
   logic [7:0]        led_src_m;
   logic [`U2_DW-1:0] cycle_m;
   // Access waiting for its ack
   logic              pend;
   logic              pend_we;
   logic [15:0]       pend_adr;
   logic [`U2_DW-1:0] pend_dat;
   logic [1:0]        pend_kind;
   logic [`U2_DW-1:0] pend_exp;
   logic              stb_seen;

   assign checks_o     = n_checks;
   assign value_errs_o = n_value_errs;
   assign proto_errs_o = n_proto_errs;

   // Per bit, 1 in src picks the hardware status bit
   function automatic logic [7:0] mix_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input u2_ctrl_pkg::irq_src_t irq);
      logic [7:0] hw;
      logic [7:0] mix;
      hw    = 8'h00;
      hw[0] = irq.serdes_link_up;
      hw[1] = irq.clk_status;
      for (int i = 0; i < 8; i++) begin
         mix[i] = src[i] ? hw[i] : sw[i];
      end
      return mix;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      n_checks++;
      if (exp !== act) begin
         n_value_errs++;
         $display("FAILED %s expected %h actual %h", name, exp, act);
      end
   endtask

   // Settings write seen on the bus
   task automatic apply_setting(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         `SR_CLK:     clk_m     = data[4:0];
         `SR_SER:     ser_m     = data[3:0];
         `SR_ADC:     adc_m     = data[3:0];
         `SR_LED:     led_sw_m  = data[7:0];
         `SR_PHY:     phy_rst_m = data[0];
         `SR_LED_SRC: led_src_m = data[7:0];
         default:     ;
      endcase
   endtask

   ////////////////////
   // Sampling on the rising edge, inputs settled since the falling edge
   always @(posedge dsp_clk_i) begin
      if (wb_rst_i) begin
         {clk_m, ser_m, adc_m, phy_rst_m, led_sw_m, led_src_m} = '0;
         cycle_m  = '0;
         pend     = 1'b0;
         stb_seen = 1'b0;
      end else begin
         // Board lines against the model
         compare_value("board_ctrl_o.clk", 32'(clk_m), 32'(board_i.clk));
         compare_value("board_ctrl_o.ser", 32'(ser_m), 32'(board_i.ser));
         compare_value("board_ctrl_o.adc", 32'(adc_m), 32'(board_i.adc));
         compare_value("board_ctrl_o.phy_reset_n", 32'(!phy_rst_m), 32'(board_i.phy_reset_n));
         compare_value("board_ctrl_o.leds", 32'(mix_leds(led_src_m, led_sw_m, irq_src_i)),
                       32'(board_i.leds));
         // Response to the access first seen last cycle
         if (pend) begin
            if (rsp_i.ack !== 1'b1) begin
               n_proto_errs++;
               $display("No ack one cycle after the access to address %h", pend_adr);
            end else if (!pend_we) begin
               if (pend_kind == EXP_DATA || pend_kind == EXP_CYCLES) begin
                  compare_value("wb_rsp_o.dat", pend_exp, rsp_i.dat);
               end
            end else if (pend_adr[15:10] == `U2_SETTINGS_BASE) begin
               apply_setting(pend_adr[9:2], pend_dat);
            end
            pend = 1'b0;
         end else if (rsp_i.ack !== 1'b0) begin
            n_proto_errs++;
            $display("Ack seen with no new access pending");
         end
         // New access
         if (req_i.cyc && req_i.stb && !stb_seen) begin
            pend      = 1'b1;
            pend_we   = req_i.we;
            pend_adr  = req_i.adr;
            pend_dat  = req_i.dat;
            pend_kind = exp_kind_i;
            // Count as it stands before this edge
            pend_exp  = (exp_kind_i == EXP_CYCLES) ? cycle_m : exp_data_i;
         end
         stb_seen = req_i.cyc & req_i.stb;
         cycle_m  = cycle_m + 1;
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_u2_ctrl.sv ====
/*
 * Control core testbench
 * Replays the bus trace with random idle gaps, watchdog on trace length
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module tb_u2_ctrl;

   localparam int CLK_NS = 40;
   localparam int RST_CYCLES = 8;
   localparam int CYCLES_PER_ENTRY = 8;
   localparam int ACK_LIMIT = 16;

   logic                     dsp_clk;
   logic                     wb_rst;
   u2_ctrl_pkg::wb_req_t     wb_req;
   u2_ctrl_pkg::wb_rsp_t     wb_rsp;
   logic [`U2_DW-1:0]        status;
   logic                     sim_mode;
   logic [3:0]               clock_divider;
   u2_ctrl_pkg::irq_src_t    irq_src;
   u2_ctrl_pkg::board_ctrl_t board_ctrl;
   logic [1:0]               exp_kind;
   logic [`U2_DW-1:0]        exp_data;
   int                       n_checks;
   int                       n_value_errs;
   int                       n_proto_errs;
   int                       trace_errs = 0;
   int                       trace_len = 0;
   bit                       trace_ok;
   logic [15:0]              lfsr;
   // Trace entries
   logic [7:0]               op_q[$];
   logic [15:0]              adr_q[$];
   logic [31:0]              dat_q[$];

   tb_clock_gen u_clock_gen (
      .dsp_clk_o (dsp_clk),
      .wb_rst_o  (wb_rst)
   );

   u2_ctrl_top dut (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .wb_req_i        (wb_req),
      .wb_rsp_o        (wb_rsp),
      .status_i        (status),
      .sim_mode_i      (sim_mode),
      .clock_divider_i (clock_divider),
      .irq_src_i       (irq_src),
      .board_ctrl_o    (board_ctrl)
   );

   tb_u2_checker u_checker (
      .dsp_clk_i    (dsp_clk),
      .wb_rst_i     (wb_rst),
      .req_i        (wb_req),
      .rsp_i        (wb_rsp),
      .irq_src_i    (irq_src),
      .board_i      (board_ctrl),
      .exp_kind_i   (exp_kind),
      .exp_data_i   (exp_data),
      .checks_o     (n_checks),
      .value_errs_o (n_value_errs),
      .proto_errs_o (n_proto_errs)
   );

   // Galois LFSR, x^16+x^14+x^13+x^11+1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   task automatic take_rand_bit(output logic b);
      b    = lfsr[0];
      lfsr = lfsr_next(lfsr);
   endtask

   task automatic load_trace(output bit ok);
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [15:0] a;
      logic [31:0] d;
      fd = $fopen("bench/u2_ctrl_trace.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Comment lines start with #
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%c %h %h", op, a, d);
               if (n == 3) begin
                  op_q.push_back(op);
                  adr_q.push_back(a);
                  dat_q.push_back(d);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////
   // Wishbone master, one access at a time
   task automatic bus_access(input logic we, input logic [15:0] adr,
                             input logic [31:0] dat, input logic [1:0] kind);
      int waited;
      @(negedge dsp_clk);
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = we ? dat : '0;
      exp_kind   = kind;
      exp_data   = dat;
      waited     = 0;
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (wb_rsp.ack !== 1'b1 && waited < ACK_LIMIT);
      if (wb_rsp.ack !== 1'b1) begin
         $display("Access to address %h got no ack, abandoned", adr);
      end else begin
         // stb stays up over the ack edge, dropped in the cycle after
         @(negedge dsp_clk);
      end
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   // 0 to 3 idle cycles, two LFSR bits
   task automatic idle_gap();
      logic b0;
      logic b1;
      take_rand_bit(b0);
      take_rand_bit(b1);
      repeat ({b1, b0}) @(negedge dsp_clk);
   endtask

   task automatic run_entry(input logic [7:0] op, input logic [15:0] adr,
                            input logic [31:0] dat);
      case (op)
         "W": bus_access(1'b1, adr, dat, 2'd0);
         "R": bus_access(1'b0, adr, dat, 2'd1);
         "C": bus_access(1'b0, adr, dat, 2'd2);
         "S": begin
            @(negedge dsp_clk);
            status = dat;
         end
         "I": begin
            @(negedge dsp_clk);
            irq_src = dat[11:0];
         end
         "M": begin
            @(negedge dsp_clk);
            sim_mode      = dat[4];
            clock_divider = dat[3:0];
         end
         default: begin
            trace_errs++;
            $display("Unknown trace operation %h", op);
         end
      endcase
   endtask

   ////////////////////
   // Main sequence
   initial begin
      wb_req        = '0;
      status        = '0;
      sim_mode      = 1'b0;
      clock_divider = 4'h0;
      irq_src       = '0;
      exp_kind      = 2'd0;
      exp_data      = '0;
      lfsr          = 16'd31;
      load_trace(trace_ok);
      trace_len = op_q.size();
      if (!trace_ok || trace_len == 0) begin
         $display("Trace file bench/u2_ctrl_trace.txt could not be read");
         $display("FAIL: see errors above");
         $finish;
      end else begin
         wait (wb_rst === 1'b0);
         // Some quiet cycles with reset values on the pins
         repeat (2) @(negedge dsp_clk);
         for (int i = 0; i < trace_len; i++) begin
            run_entry(op_q[i], adr_q[i], dat_q[i]);
            idle_gap();
         end
         // Let the last register update reach the checker
         repeat (4) @(negedge dsp_clk);
         $display("Checks %0d, value errors %0d, protocol errors %0d, trace errors %0d",
                  n_checks, n_value_errs, n_proto_errs, trace_errs);
         if (n_checks > 0 && n_value_errs == 0 && n_proto_errs == 0 && trace_errs == 0) begin
            $display("PASS: all tests");
         end else begin
            $display("FAIL: see errors above");
         end
         $finish;
      end
   end

   // Watchdog, sized from the trace length
   initial begin
      wait (trace_len > 0);
      #((trace_len * CYCLES_PER_ENTRY + RST_CYCLES) * CLK_NS);
      $display("Watchdog expired, trace of %0d entries did not finish", trace_len);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/u2_ctrl_trace.txt ====
# Control core bus trace, one entry per line: op addr data (hex)
# W write, R read expecting data, C cycle count read, S status_i, I irq_src_i, M mode bits
# Reset values, unused words, unmapped and settings-space reads
C cc3c 00000000
R cc00 00000000
R cc1c 00000000
R 1000 00000000
R d400 00000000
# Setting registers, upper data bits ignored
W d400 fffffffb
W d404 0000000a
W d408 00000005
W d410 00000001
W d414 ffffffff
# LED software value and source select
W d40c 000000a5
I 0000 00000c00
W d420 00000003
I 0000 00000400
W d420 00000002
W d410 00000000
W 0004 12345678
# Status word and highest-bit encoder
S 0000 8000a5f0
R cc20 8000a5f0
R cc38 0000000f
S 0000 00000120
R cc38 00000008
S 0000 00000001
R cc38 00000000
S 0000 ffff0000
R cc38 00000010
# Mode and interrupt words
M 0000 00000016
R cc24 80000006
M 0000 00000003
R cc24 00000003
I 0000 00000a5c
R cc34 00000a5c
C cc3c 00000000
W d400 00000000
W d408 0000000f
C cc3c 00000000
R 8000 00000000

// ==== hw/control_regs.sv ====
/*
 * Board control setting registers
 * Clock, SERDES, ADC, PHY reset and LED lines, with per-bit LED source
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module control_regs (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  u2_ctrl_pkg::set_bus_t    set_i,
   input  u2_ctrl_pkg::irq_src_t    irq_src_i,
   output u2_ctrl_pkg::board_ctrl_t ctrl_o
);

   u2_ctrl_pkg::set_word_u set_w;
   logic [4:0]             clk_q;
   logic [3:0]             ser_q;
   logic [3:0]             adc_q;
   logic                   phy_reset_q;
   logic [7:0]             led_sw_q;
   logic [7:0]             led_src_q;
   logic [7:0]             led_hw;

   // One data word, read per target group
   assign set_w.raw = set_i.data;

   ////////////////////
   // Setting registers
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_q       <= '0;
         ser_q       <= '0;
         adc_q       <= '0;
         phy_reset_q <= 1'b0;
         led_sw_q    <= '0;
         led_src_q   <= '0;
      end else if (set_i.stb) begin
         case (set_i.addr)
            `SR_CLK: begin
               // Clock gen lines
               clk_q <= {set_w.clk.clock_ready, set_w.clk.clk_en, set_w.clk.clk_sel};
            end
            `SR_SER: begin
               ser_q <= {set_w.ser.enable, set_w.ser.prbsen,
                         set_w.ser.loopen, set_w.ser.rx_en};
            end
            `SR_ADC: begin
               adc_q <= {set_w.adc.oe_a, set_w.adc.on_a,
                         set_w.adc.oe_b, set_w.adc.on_b};
            end
            `SR_LED: begin
               led_sw_q <= set_w.raw[7:0];
            end
            `SR_PHY: begin
               // Active high here, pin is inverted
               phy_reset_q <= set_w.raw[0];
            end
            `SR_LED_SRC: begin
               led_src_q <= set_w.raw[7:0];
            end
            default: begin
               // Other addresses belong to nobody here
               clk_q <= clk_q;
            end
         endcase
      end
   end

   ////////////////////
   // LED source select
   // 1 picks hardware status, 0 picks software value
   assign led_hw = {6'b0, irq_src_i.clk_status, irq_src_i.serdes_link_up};

   assign ctrl_o.clk         = clk_q;
   assign ctrl_o.ser         = ser_q;
   assign ctrl_o.adc         = adc_q;
   assign ctrl_o.phy_reset_n = ~phy_reset_q;
   assign ctrl_o.leds        = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

// ==== hw/readback_mux.sv ====
/*
 * Status readback slave
 * Sixteen words incl. mode, interrupt vector, status encoder and cycle count
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module readback_mux (
   input  wire                   dsp_clk,
   input  wire                   wb_rst,
   input  u2_ctrl_pkg::wb_req_t  req_i,
   output u2_ctrl_pkg::wb_rsp_t  rsp_o,
   input  wire [`U2_DW-1:0]      status_i,
   input  wire                   sim_mode_i,
   input  wire [3:0]             clock_divider_i,
   input  u2_ctrl_pkg::irq_src_t irq_src_i
);

   logic [`U2_DW-1:0] cycle_count;
   logic [`U2_DW-1:0] mode_word;
   logic [`U2_DW-1:0] irq_word;
   logic [`U2_DW-1:0] enc_word;
   logic [4:0]        status_enc;
   logic [`U2_DW-1:0] rd_word;
   logic [`U2_DW-1:0] dat_q;
   logic              ack_q;
   logic              accept;

   ////////////////////
   // Free-running cycle counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 1'b1;
      end
   end

   // Highest set bit of low status half
   // Later iterations win, so top bit ends up in enc
   always_comb begin
      status_enc = `U2_NO_BIT_SET;
      for (int i = 0; i < 16; i++) begin
         if (status_i[i]) begin
            status_enc = 5'(i);
         end
      end
   end

   // Assembled words
   assign mode_word = {sim_mode_i, 27'b0, clock_divider_i};
   assign irq_word  = {20'b0, irq_src_i};
   assign enc_word  = {27'b0, status_enc};

   ////////////////////
   // Word select on adr[5:2]
   always_comb begin
      case (req_i.adr[5:2])
         `RB_STATUS:     rd_word = status_i;
         `RB_MODE:       rd_word = mode_word;
         `RB_IRQ:        rd_word = irq_word;
         `RB_STATUS_ENC: rd_word = enc_word;
         `RB_CYCLES:     rd_word = cycle_count;
         // Buffer pool words and spares
         default:        rd_word = '0;
      endcase
   end

   assign accept = req_i.cyc & req_i.stb & ~ack_q;

   // Ack, one cycle per access
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;
      end
   end

   // Read data, captured with the ack
   always_ff @(posedge dsp_clk) begin
      if (accept) begin
         dat_q <= rd_word;
      end
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = dat_q;

endmodule

`default_nettype wire

// ==== hw/settings_bus.sv ====
/*
 * Settings bus slave
 * Each accepted write becomes a one-cycle strobe with word address and data
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module settings_bus (
   input  wire                   dsp_clk,
   input  wire                   wb_rst,
   input  u2_ctrl_pkg::wb_req_t  req_i,
   output u2_ctrl_pkg::wb_rsp_t  rsp_o,
   output u2_ctrl_pkg::set_bus_t set_o
);

   logic              ack_q;
   logic              stb_q;
   logic [7:0]        addr_q;
   logic [`U2_DW-1:0] data_q;
   logic              accept;

   // First cycle of a strobed access
   assign accept = req_i.cyc & req_i.stb & ~ack_q;

   // Ack and strobe, control state
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= accept;
         stb_q <= accept & req_i.we;
      end
   end

   // Word address and write data
   always_ff @(posedge dsp_clk) begin
      if (accept) begin
         addr_q <= req_i.adr[9:2];
         data_q <= req_i.dat;
      end
   end

   // Settings space is write only
   assign rsp_o.ack  = ack_q;
   assign rsp_o.dat  = '0;
   assign set_o.stb  = stb_q;
   assign set_o.addr = addr_q;
   assign set_o.data = data_q;

endmodule

`default_nettype wire

// ==== hw/u2_ctrl_pkg.sv ====
/*
 * Control core types
 * Wishbone request and response, settings bus and board control groups
 */
`default_nettype none
`include "u2_ctrl_consts.svh"

package u2_ctrl_pkg;

   // Master to slave
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [`U2_AW-1:0] adr;
      logic [`U2_DW-1:0] dat;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic              ack;
      logic [`U2_DW-1:0] dat;
   } wb_rsp_t;

   // One-cycle settings strobe with word address
   typedef struct packed {
      logic              stb;
      logic [7:0]        addr;
      logic [`U2_DW-1:0] data;
   } set_bus_t;

   // Clock generator lines, low 5 bits
   typedef struct packed {
      logic [26:0] pad;
      logic        clock_ready;
      logic [1:0]  clk_en;
      logic [1:0]  clk_sel;
   } clk_ctrl_t;

   // SERDES enables
   typedef struct packed {
      logic [27:0] pad;
      logic        enable;
      logic        prbsen;
      logic        loopen;
      logic        rx_en;
   } ser_ctrl_t;

   // ADC power and output enable
   typedef struct packed {
      logic [27:0] pad;
      logic        oe_a;
      logic        on_a;
      logic        oe_b;
      logic        on_b;
   } adc_ctrl_t;

   // Same settings word, decoded per target register
   typedef union packed {
      logic [`U2_DW-1:0] raw;
      clk_ctrl_t         clk;
      ser_ctrl_t         ser;
      adc_ctrl_t         adc;
   } set_word_u;

   // Interrupt sources, MSB first
   typedef struct packed {
      logic clk_status;
      logic serdes_link_up;
      logic uart_tx;
      logic uart_rx;
      logic pps;
      logic overrun;
      logic underrun;
      logic phy_int_n;
      logic i2c;
      logic spi;
      logic timer;
      logic buffer;
   } irq_src_t;

   // All board control pins
   typedef struct packed {
      logic [4:0] clk;
      logic [3:0] ser;
      logic [3:0] adc;
      logic       phy_reset_n;
      logic [7:0] leds;
   } board_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/u2_ctrl_top.sv ====
/*
 * USRP2 control and status top
 * One Wishbone master into settings bus and readback mux
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module u2_ctrl_top (
   input  wire                    dsp_clk,
   input  wire                    wb_rst,
   input  u2_ctrl_pkg::wb_req_t   wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t   wb_rsp_o,
   input  wire [`U2_DW-1:0]       status_i,
   input  wire                    sim_mode_i,
   input  wire [3:0]              clock_divider_i,
   input  u2_ctrl_pkg::irq_src_t  irq_src_i,
   output u2_ctrl_pkg::board_ctrl_t board_ctrl_o
);

   // Per-slave request and response
   u2_ctrl_pkg::wb_req_t  set_req;
   u2_ctrl_pkg::wb_req_t  rb_req;
   u2_ctrl_pkg::wb_rsp_t  set_rsp;
   u2_ctrl_pkg::wb_rsp_t  rb_rsp;
   u2_ctrl_pkg::set_bus_t set_bus;

   ////////////////////
   // Bus fabric
   wb_ctrl_decoder u_decoder (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .req_i     (wb_req_i),
      .set_rsp_i (set_rsp),
      .rb_rsp_i  (rb_rsp),
      .set_req_o (set_req),
      .rb_req_o  (rb_req),
      .rsp_o     (wb_rsp_o)
   );

   ////////////////////
   // Settings slave and its registers
   settings_bus u_settings_bus (
      .dsp_clk (dsp_clk),
      .wb_rst  (wb_rst),
      .req_i   (set_req),
      .rsp_o   (set_rsp),
      .set_o   (set_bus)
   );

   control_regs u_control_regs (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .set_i     (set_bus),
      .irq_src_i (irq_src_i),
      .ctrl_o    (board_ctrl_o)
   );

   ////////////////////
   // Status readback slave
   readback_mux u_readback_mux (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .req_i           (rb_req),
      .rsp_o           (rb_rsp),
      .status_i        (status_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .irq_src_i       (irq_src_i)
   );

endmodule

`default_nettype wire

// ==== hw/wb_ctrl_decoder.sv ====
/*
 * Wishbone slave decoder
 * Routes the master strobe by upper address bits, acks holes, merges replies
 */
`timescale 1ns/100ps
`default_nettype none
`include "u2_ctrl_consts.svh"

module wb_ctrl_decoder (
   input  wire                  dsp_clk,
   input  wire                  wb_rst,
   input  u2_ctrl_pkg::wb_req_t req_i,
   input  u2_ctrl_pkg::wb_rsp_t set_rsp_i,
   input  u2_ctrl_pkg::wb_rsp_t rb_rsp_i,
   output u2_ctrl_pkg::wb_req_t set_req_o,
   output u2_ctrl_pkg::wb_req_t rb_req_o,
   output u2_ctrl_pkg::wb_rsp_t rsp_o
);

   logic [`U2_DECODE_W-1:0] adr_top;
   logic                    hit_set;
   logic                    hit_rb;
   logic                    hit_none;
   logic                    none_ack;

   // Top address bits pick the slave
   assign adr_top  = req_i.adr[`U2_AW-1 -: `U2_DECODE_W];
   assign hit_set  = (adr_top == `U2_SETTINGS_BASE);
   assign hit_rb   = (adr_top == `U2_READBACK_BASE);
   assign hit_none = ~hit_set & ~hit_rb;

   // Only the matching slave sees stb
   always_comb begin
      set_req_o     = req_i;
      set_req_o.stb = req_i.stb & hit_set;
      rb_req_o      = req_i;
      rb_req_o.stb  = req_i.stb & hit_rb;
   end

   ////////////////////
   // Unmapped space
   // Single-cycle ack, never twice for one stb
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= req_i.cyc & req_i.stb & hit_none & ~none_ack;
      end
   end

   ////////////////////
   // Response merge
   // Only one slave can ack at a time
   always_comb begin
      rsp_o.ack = set_rsp_i.ack | rb_rsp_i.ack | none_ack;
      if (hit_rb) begin
         rsp_o.dat = rb_rsp_i.dat;
      end else if (hit_set) begin
         rsp_o.dat = set_rsp_i.dat;
      end else begin
         // Holes read as zero
         rsp_o.dat = '0;
      end
   end

endmodule

`default_nettype wire

// ==== include/u2_ctrl_consts.svh ====
/*
 * USRP2 control core constants
 * Bus widths, slave decode bases, setting addresses and readback word slots
 */
`ifndef U2_CTRL_CONSTS_SVH
`define U2_CTRL_CONSTS_SVH

// Wishbone widths
`define U2_DW 32
`define U2_AW 16

// Upper address bits used for slave select
`define U2_DECODE_W 6
`define U2_SETTINGS_BASE 6'b110101
`define U2_READBACK_BASE 6'b110011

// Setting register addresses, 8 bits wide
`define SR_CLK 8'd0
`define SR_SER 8'd1
`define SR_ADC 8'd2
`define SR_LED 8'd3
`define SR_PHY 8'd4
`define SR_LED_SRC 8'd8

// Readback word slots, 16 in all
`define RB_STATUS 4'd8
`define RB_MODE 4'd9
`define RB_IRQ 4'd13
`define RB_STATUS_ENC 4'd14
`define RB_CYCLES 4'd15

// Encoder result with no status bit set
`define U2_NO_BIT_SET 5'd16

`endif

// ==== u2_ctrl_top.f ====
+incdir+include
hw/u2_ctrl_pkg.sv
hw/wb_ctrl_decoder.sv
hw/settings_bus.sv
hw/control_regs.sv
hw/readback_mux.sv
hw/u2_ctrl_top.sv
bench/tb_clock_gen.sv
bench/tb_u2_checker.sv
bench/tb_u2_ctrl.sv
